//--- sources.f
+incdir+design
design/exec_pkg.sv
design/exec_ctrl.sv
design/alu_unit.sv
design/mul_unit.sv
design/div_unit.sv
design/exmem_stage.sv
design/data_mem.sv
design/memwb_stage.sv
design/exec_backend.sv
tb/exec_checker.sv
tb/tb_exec_backend.sv

//--- Bender.yml
package:
  name: exec_backend

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/exec_pkg.sv
      - design/exec_ctrl.sv
      - design/alu_unit.sv
      - design/mul_unit.sv
      - design/div_unit.sv
      - design/exmem_stage.sv
      - design/data_mem.sv
      - design/memwb_stage.sv
      - design/exec_backend.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/exec_checker.sv
      - tb/tb_exec_backend.sv

//--- tb/tb_exec_backend.sv
// tb_exec_backend: clock, reset, issue and APB stimulus, test sequence and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_exec_backend;
    import exec_pkg::*;

    // ops issued by the alu, load/store, mul, div and flush tests
    localparam int OP_COUNT     = 200 + 40 + 100 + 2 * 20 + 13;
    localparam int LIMIT_CYCLES = OP_COUNT * 40 + 2000;

    logic        clk;
    logic        reset;
    logic        flush;
    issue_op_t   issue;
    logic        issue_ready;
    cpl_t        alu_cpl;
    cpl_t        mul_cpl;
    cpl_t        div_cpl;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    xlen_t       pwdata;
    xlen_t       prdata;
    logic        pready;
    int          seed;
    int          last_errors;
    pc_t         pc_next;
    ptag_t       tag_next;

    exec_backend uut (
        .clk(clk), .reset(reset), .flush(flush), .issue(issue), .issue_ready(issue_ready),
        .alu_cpl(alu_cpl), .mul_cpl(mul_cpl), .div_cpl(div_cpl),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    exec_checker chk (
        .clk(clk), .reset(reset), .flush(flush), .issue(issue), .issue_ready(issue_ready),
        .alu_cpl(alu_cpl), .mul_cpl(mul_cpl), .div_cpl(div_cpl),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic xlen_t rnd();
        return $random(seed);
    endfunction

    function automatic issue_op_t make_op(input op_class_e cls, input funct3_t f3,
                                          input logic alt, input xlen_t a, input xlen_t b,
                                          input xlen_t imm);
        issue_op_t o;
        o = '{valid: 1'b1, cls: cls, funct3: f3, alt: alt, a: a, b: b, imm: imm,
              pc: pc_next, tag: tag_next};
        pc_next  = pc_next + 32'd4;
        tag_next = tag_next + 1'b1;
        return o;
    endfunction

    // returns right after the edge that accepted the op
    task automatic send(input issue_op_t o);
        issue <= o;
        @(posedge clk);
        while (!issue_ready) @(posedge clk);
    endtask

    task automatic apb_access(input logic wr, input int word, input xlen_t data);
        paddr   <= 12'(word * 4);
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic drain();
        issue <= '0;
        @(posedge clk);
        while (chk.pending != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic report(input string name);
        $display("test %-16s %s (%0d errors)", name,
                 (chk.errors == last_errors) ? "ok" : "bad", chk.errors - last_errors);
        last_errors = chk.errors;
    endtask

    initial begin
        #(LIMIT_CYCLES * 4);
        $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] r;
        funct3_t     f3;
        funct3_t     ld_f3 [0:4];
        xlen_t       apb_data [0:15];
        seed        = 32'hef47_d809;
        last_errors = 0;
        pc_next     = 32'h0000_1000;
        tag_next    = '0;
        ld_f3       = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        reset       = 1'b1;
        flush       = 1'b0;
        issue       = '0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < 32; i++) apb_access(1'b1, 192 + i, rnd());
        for (int i = 0; i < 32; i++) apb_access(1'b0, 192 + i, '0);
        drain();
        report("apb readback");

        for (int i = 0; i < 200; i++) begin
            r = rnd();
            send(make_op(CLS_ALU, r[2:0], r[3], rnd(), rnd(), '0));
        end
        drain();
        report("alu ops");

        for (int i = 0; i < 64; i++) apb_access(1'b1, i, rnd());
        for (int i = 0; i < 16; i++) apb_data[i] = rnd();
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    r = rnd();
                    if (r[6]) begin
                        f3 = funct3_t'(r[9:8] % 3);
                        send(make_op(CLS_STORE, f3, 1'b0, {r[5:0], 2'b00}, rnd(),
                                     (f3 == 0) ? r[11:10] : (f3 == 1) ? {r[11], 1'b0} : 0));
                    end else begin
                        f3 = ld_f3[r[14:12] % 5];
                        send(make_op(CLS_LOAD, f3, 1'b0, {r[5:0], 2'b00}, '0,
                                     (f3[1:0] == 0) ? r[11:10] : (f3[1:0] == 1) ?
                                     {r[11], 1'b0} : 0));
                    end
                end
                issue <= '0;
            end
            begin
                for (int i = 0; i < 16; i++) apb_access(1'b1, 128 + i, apb_data[i]);
            end
        join
        drain();
        for (int i = 0; i < 64; i++) apb_access(1'b0, i, '0);
        for (int i = 0; i < 16; i++) apb_access(1'b0, 128 + i, '0);
        drain();
        report("loads/stores");

        for (int i = 0; i < 100; i++) send(make_op(CLS_MUL, '0, 1'b0, rnd(), rnd(), '0));
        drain();
        report("multiplies");

        for (int i = 0; i < 20; i++) begin
            r = rnd();
            send(make_op(CLS_DIV, r[0] ? 3'd7 : 3'd5, 1'b0, rnd(),
                         (i % 5 == 0) ? '0 : rnd() >> r[5:1], '0));
            // held back until the divider finishes
            send(make_op(CLS_ALU, 3'd0, 1'b0, rnd(), rnd(), '0));
        end
        drain();
        report("divides");

        send(make_op(CLS_MUL, '0, 1'b0, rnd(), rnd(), '0));
        send(make_op(CLS_STORE, 3'd2, 1'b0, 32'd40, 32'hdead_beef, '0));
        send(make_op(CLS_DIV, 3'd5, 1'b0, rnd(), rnd(), '0));
        issue <= make_op(CLS_ALU, 3'd4, 1'b0, rnd(), rnd(), '0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        issue <= '0;
        repeat (40) @(posedge clk);
        // second flush meets an op that issue_ready would have taken
        send(make_op(CLS_MUL, '0, 1'b0, rnd(), rnd(), '0));
        issue <= make_op(CLS_STORE, 3'd2, 1'b0, 32'd44, 32'h0bad_f00d, '0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        issue <= '0;
        repeat (10) @(posedge clk);
        for (int i = 0; i < 5; i++) begin
            r = rnd();
            send(make_op(CLS_ALU, r[2:0], r[3], rnd(), rnd(), '0));
        end
        send(make_op(CLS_MUL, '0, 1'b0, rnd(), rnd(), '0));
        send(make_op(CLS_DIV, 3'd7, 1'b0, rnd(), rnd(), '0));
        drain();
        apb_access(1'b0, 10, '0);
        apb_access(1'b0, 11, '0);
        drain();
        report("flush");

        $display("checks %0d, errors %0d", chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/exec_checker.sv
// exec_checker: reference model of the back end, memory model and completion/APB comparison
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  exec_pkg::issue_op_t issue,
    input  logic                issue_ready,
    input  exec_pkg::cpl_t      alu_cpl,
    input  exec_pkg::cpl_t      mul_cpl,
    input  exec_pkg::cpl_t      div_cpl,
    input  logic [11:0]         paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  exec_pkg::xlen_t     pwdata,
    input  exec_pkg::xlen_t     prdata,
    input  logic                pready
);
    import exec_pkg::*;

    issue_op_t alu_q[$];
    issue_op_t mul_q[$];
    issue_op_t div_q[$];
    xlen_t     mem_model [0:`EXEC_MEM_WORDS-1];
    issue_op_t op;
    logic      div_busy;
    logic [2:0] store_due;
    int        errors;
    int        checks;
    int        pending;

    function automatic xlen_t alu_ref(input issue_op_t o);
        logic [4:0] sh;
        sh = o.b[4:0];
        case (o.funct3)
            3'd0: return o.alt ? o.a + ~o.b + 32'd1 : o.a + o.b;
            3'd1: return o.a << sh;
            3'd2: return ($signed(o.a) < $signed(o.b)) ? 32'd1 : 32'd0;
            3'd3: return (o.a < o.b) ? 32'd1 : 32'd0;
            3'd4: return o.a ^ o.b;
            3'd5: begin
                if (o.alt && o.a[31]) return (o.a >> sh) | ~(32'hffff_ffff >> sh);
                return o.a >> sh;
            end
            3'd6: return o.a | o.b;
            default: return o.a & o.b;
        endcase
    endfunction

    function automatic xlen_t div_ref(input issue_op_t o);
        if (o.b == 0) return (o.funct3 == 3'd7) ? o.a : 32'hffff_ffff;
        return (o.funct3 == 3'd7) ? o.a % o.b : o.a / o.b;
    endfunction

    // loads read the model, stores update it, both in completion order
    function automatic xlen_t alu_expect(input issue_op_t o);
        xlen_t addr;
        xlen_t w;
        xlen_t lane;
        addr = o.a + o.imm;
        w    = mem_model[addr[9:2]];
        lane = w >> (8 * addr[1:0]);
        if (o.cls == CLS_LOAD) begin
            case (o.funct3)
                3'd0: return xlen_t'($signed(lane[7:0]));
                3'd1: return xlen_t'($signed(lane[15:0]));
                3'd4: return {24'h0, lane[7:0]};
                3'd5: return {16'h0, lane[15:0]};
                default: return w;
            endcase
        end
        if (o.cls == CLS_STORE) begin
            case (o.funct3)
                3'd0: w[8*addr[1:0] +: 8] = o.b[7:0];
                3'd1: w[16*addr[1] +: 16] = o.b[15:0];
                default: w = o.b;
            endcase
            mem_model[addr[9:2]] = w;
            return '0;
        end
        return alu_ref(o);
    endfunction

    task automatic compare(input string port, input cpl_t got, input issue_op_t o,
                           input xlen_t exp);
        checks++;
        if (got.value !== exp) begin
            errors++;
            $display("ERR %s.value exp=%h got=%h", port, exp, got.value);
        end
        if (got.pc !== o.pc) begin
            errors++;
            $display("ERR %s.pc exp=%h got=%h", port, o.pc, got.pc);
        end
        if (got.tag !== o.tag) begin
            errors++;
            $display("ERR %s.tag exp=%h got=%h", port, o.tag, got.tag);
        end
    endtask

    task automatic unexpected(input string port, input cpl_t got);
        errors++;
        $display("%s fired with no op outstanding (tag %h)", port, got.tag);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        pending = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            alu_q.delete();
            mul_q.delete();
            div_q.delete();
            div_busy  = 1'b0;
            store_due = '0;
        end else begin
            // a store accepted three edges back writes memory at this edge
            if (pready !== !store_due[2]) begin
                errors++;
                $display("ERR pready exp=%h got=%h", !store_due[2], pready);
            end
            if (div_busy && issue_ready && !div_cpl.valid) begin
                errors++;
                $display("issue_ready was high while the divider was running");
            end
            if (alu_cpl.valid) begin
                if (alu_q.size() == 0) unexpected("alu_cpl", alu_cpl);
                else begin
                    op = alu_q.pop_front();
                    compare("alu_cpl", alu_cpl, op, alu_expect(op));
                end
            end
            if (mul_cpl.valid) begin
                if (mul_q.size() == 0) unexpected("mul_cpl", mul_cpl);
                else begin
                    op = mul_q.pop_front();
                    compare("mul_cpl", mul_cpl, op, op.a * op.b);
                end
            end
            if (div_cpl.valid) begin
                div_busy = 1'b0;
                if (!issue_ready) begin
                    errors++;
                    $display("issue_ready stayed low in the divider's done cycle");
                end
                if (div_q.size() == 0) unexpected("div_cpl", div_cpl);
                else begin
                    op = div_q.pop_front();
                    compare("div_cpl", div_cpl, op, div_ref(op));
                end
            end
            if (psel && penable && pready) begin
                if (pwrite) begin
                    mem_model[paddr[9:2]] = pwdata;
                end else begin
                    checks++;
                    if (prdata !== mem_model[paddr[9:2]]) begin
                        errors++;
                        $display("ERR prdata exp=%h got=%h", mem_model[paddr[9:2]], prdata);
                    end
                end
            end
            store_due = {store_due[1:0], 1'b0};
            if (issue.valid && issue_ready && !flush) begin
                case (issue.cls)
                    CLS_MUL: mul_q.push_back(issue);
                    CLS_DIV: begin
                        div_q.push_back(issue);
                        div_busy = 1'b1;
                    end
                    CLS_STORE: begin
                        alu_q.push_back(issue);
                        store_due[0] = 1'b1;
                    end
                    default: alu_q.push_back(issue);
                endcase
            end
            // everything still in flight is cancelled
            if (flush) begin
                alu_q.delete();
                mul_q.delete();
                div_q.delete();
                div_busy  = 1'b0;
                store_due = '0;
            end
        end
        pending = alu_q.size() + mul_q.size() + div_q.size();
    end

endmodule

`default_nettype wire

//--- design/exec_backend.sv
// exec_backend: top level of the execution back end
`timescale 1ns/1ps
`default_nettype none

module exec_backend (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  exec_pkg::issue_op_t issue,
    output logic                issue_ready,
    output exec_pkg::cpl_t      alu_cpl,
    output exec_pkg::cpl_t      mul_cpl,
    output exec_pkg::cpl_t      div_cpl,
    input  logic [11:0]         paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  exec_pkg::xlen_t     pwdata,
    output exec_pkg::xlen_t     prdata,
    output logic                pready
);

    exec_pkg::issue_op_t alu_in;
    exec_pkg::issue_op_t mul_in;
    exec_pkg::issue_op_t div_in;
    exec_pkg::ex_op_t    ex_alu;
    exec_pkg::ex_op_t    ex_mem;
    exec_pkg::xlen_t     mem_rdata;
    logic                kill;
    logic                div_done;
    logic                mem_we;
    logic                mem_re;

    exec_ctrl u_ctrl (
        .clk(clk), .reset(reset), .flush(flush), .issue(issue), .issue_ready(issue_ready),
        .alu_in(alu_in), .mul_in(mul_in), .div_in(div_in), .div_done(div_done), .kill(kill)
    );

    alu_unit u_alu (.clk(clk), .reset(reset), .kill(kill), .op(alu_in), .ex(ex_alu));

    mul_unit u_mul (.clk(clk), .reset(reset), .kill(kill), .op(mul_in), .cpl(mul_cpl));

    div_unit u_div (
        .clk(clk), .reset(reset), .kill(kill), .op(div_in), .cpl(div_cpl), .done(div_done)
    );

    exmem_stage u_exmem (
        .clk(clk), .reset(reset), .kill(kill), .ex_in(ex_alu), .ex_out(ex_mem),
        .mem_we(mem_we), .mem_re(mem_re)
    );

    data_mem u_dmem (
        .clk(clk), .reset(reset), .addr(ex_mem.result), .we(mem_we), .re(mem_re),
        .funct3(ex_mem.funct3), .wdata(ex_mem.store_data), .rdata(mem_rdata),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    memwb_stage u_memwb (
        .clk(clk), .reset(reset), .kill(kill), .ex_in(ex_mem), .rdata(mem_rdata),
        .cpl(alu_cpl)
    );

endmodule

`default_nettype wire

//--- design/memwb_stage.sv
// memwb_stage: MEM/WB register, load extension and alu completion port
`timescale 1ns/1ps
`default_nettype none

module memwb_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             kill,
    input  exec_pkg::ex_op_t ex_in,
    input  exec_pkg::xlen_t  rdata,
    output exec_pkg::cpl_t   cpl
);
    import exec_pkg::*;

    ex_op_t wb;
    xlen_t  word;
    xlen_t  load_val;
    xlen_t  value;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb       <= ex_in;
            wb.valid <= ex_in.valid && !kill;
        end
    end

    // bring the addressed byte lane down to bit 0
    always_comb begin
        word = rdata >> {wb.result[1:0], 3'b000};
        case (wb.funct3)
            3'd0: load_val = {{24{word[7]}}, word[7:0]};
            3'd1: load_val = {{16{word[15]}}, word[15:0]};
            3'd4: load_val = {24'h000000, word[7:0]};
            3'd5: load_val = {16'h0000, word[15:0]};
            default: load_val = rdata;
        endcase
        case (wb.cls)
            CLS_LOAD: value = load_val;
            CLS_STORE: value = '0;
            default: value = wb.result;
        endcase
    end

    assign cpl = '{valid: wb.valid, value: value, pc: wb.pc, tag: wb.tag};

endmodule

`default_nettype wire

//--- design/data_mem.sv
// data_mem: word array with byte-merged pipeline port and APB host port
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module data_mem (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::xlen_t   addr,
    input  logic              we,
    input  logic              re,
    input  exec_pkg::funct3_t funct3,
    input  exec_pkg::xlen_t   wdata,
    output exec_pkg::xlen_t   rdata,
    input  logic [11:0]       paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  exec_pkg::xlen_t   pwdata,
    output exec_pkg::xlen_t   prdata,
    output logic              pready
);
    import exec_pkg::*;

    localparam int IDX_W = $clog2(`EXEC_MEM_WORDS);

    xlen_t            mem [0:`EXEC_MEM_WORDS-1];
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] pidx;
    logic [3:0]       be;
    xlen_t            lane_data;
    logic             apb_wr;

    assign widx = addr[IDX_W+1:2];
    assign pidx = paddr[IDX_W+1:2];

    // host waits out the cycle of a pipeline store
    assign pready = !we;
    assign apb_wr = psel && penable && pwrite && pready;
    assign prdata = mem[pidx];

    always_comb begin
        case (funct3)
            3'd0: begin
                be        = 4'b0001 << addr[1:0];
                lane_data = {4{wdata[7:0]}};
            end
            3'd1: begin
                be        = 4'b0011 << {addr[1], 1'b0};
                lane_data = {2{wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem[widx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end else if (apb_wr) begin
            mem[pidx] <= pwdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[widx];
        end
    end

endmodule

`default_nettype wire

//--- design/exmem_stage.sv
// exmem_stage: EX/MEM register and data memory request
`timescale 1ns/1ps
`default_nettype none

module exmem_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             kill,
    input  exec_pkg::ex_op_t ex_in,
    output exec_pkg::ex_op_t ex_out,
    output logic             mem_we,
    output logic             mem_re
);
    import exec_pkg::*;

    logic keep;

    assign keep = ex_in.valid && !kill;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_out <= '0;
            mem_we <= 1'b0;
            mem_re <= 1'b0;
        end else begin
            ex_out       <= ex_in;
            ex_out.valid <= keep;
            mem_we       <= keep && (ex_in.cls == CLS_STORE);
            mem_re       <= keep && (ex_in.cls == CLS_LOAD);
        end
    end

endmodule

`default_nettype wire

//--- design/div_unit.sv
// div_unit: iterative unsigned divide and remainder, one quotient bit per cycle
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module div_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                kill,
    input  exec_pkg::issue_op_t op,
    output exec_pkg::cpl_t      cpl,
    output logic                done
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(`EXEC_DIV_CYCLES);

    div_state_e         state;
    logic [CNT_W-1:0]   cnt;
    xlen_t              quo;
    xlen_t              rem;
    xlen_t              dvs;
    funct3_t            fn;
    pc_t                pc;
    ptag_t              tag;
    logic [`EXEC_XLEN+1:0] diff;
    logic               neg;

    // trial subtract of the shifted partial remainder
    assign diff = {1'b0, rem, quo[`EXEC_XLEN-1]} - {2'b00, dvs};
    assign neg  = diff[`EXEC_XLEN+1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else if (kill) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: begin
                    cnt <= '0;
                    if (op.valid) state <= DIV_RUN;
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`EXEC_DIV_CYCLES - 1)) state <= DIV_DONE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // divisor zero keeps every trial positive: all-ones quotient, dividend remainder
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE) begin
            quo <= op.a;
            rem <= '0;
            dvs <= op.b;
            fn  <= op.funct3;
            pc  <= op.pc;
            tag <= op.tag;
        end else if (state == DIV_RUN) begin
            quo <= {quo[`EXEC_XLEN-2:0], !neg};
            rem <= neg ? {rem[`EXEC_XLEN-2:0], quo[`EXEC_XLEN-1]} : diff[`EXEC_XLEN-1:0];
        end
    end

    assign done = (state == DIV_DONE);
    assign cpl  = '{valid: done, value: (fn == 3'd7) ? rem : quo, pc: pc, tag: tag};

endmodule

`default_nettype wire

//--- design/mul_unit.sv
// mul_unit: pipelined multiplier returning the low word of a * b
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module mul_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                kill,
    input  exec_pkg::issue_op_t op,
    output exec_pkg::cpl_t      cpl
);
    import exec_pkg::*;

    localparam int LAST = `EXEC_MUL_STAGES - 1;

    logic        s0_valid;
    pc_t         s0_pc;
    ptag_t       s0_tag;
    xlen_t       s0_low;
    logic [15:0] s0_cross;
    cpl_t        pipe [1:LAST];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s0_valid <= 1'b0;
            s0_pc    <= '0;
            s0_tag   <= '0;
            s0_low   <= '0;
            s0_cross <= '0;
            for (int i = 1; i <= LAST; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            // partial products, upper cross terms only matter mod 2^16
            s0_valid <= op.valid && !kill;
            s0_pc    <= op.pc;
            s0_tag   <= op.tag;
            s0_low   <= op.a[15:0] * op.b[15:0];
            s0_cross <= op.a[15:0] * op.b[31:16] + op.a[31:16] * op.b[15:0];
            pipe[1]  <= '{valid: s0_valid && !kill, value: s0_low + {s0_cross, 16'h0000},
                          pc: s0_pc, tag: s0_tag};
            for (int i = 2; i <= LAST; i++) begin
                pipe[i]       <= pipe[i-1];
                pipe[i].valid <= pipe[i-1].valid && !kill;
            end
        end
    end

    assign cpl = pipe[LAST];

endmodule

`default_nettype wire

//--- design/alu_unit.sv
// alu_unit: EX-stage integer ALU and load/store address generation
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                kill,
    input  exec_pkg::issue_op_t op,
    output exec_pkg::ex_op_t    ex
);
    import exec_pkg::*;

    xlen_t res;

    always_comb begin
        res = op.a + op.imm;
        if (op.cls == CLS_ALU) begin
            case (op.funct3)
                3'd0: res = op.alt ? op.a - op.b : op.a + op.b;
                3'd1: res = op.a << op.b[4:0];
                3'd2: res = xlen_t'($signed(op.a) < $signed(op.b));
                3'd3: res = xlen_t'(op.a < op.b);
                3'd4: res = op.a ^ op.b;
                3'd5: res = op.alt ? xlen_t'($signed(op.a) >>> op.b[4:0]) : op.a >> op.b[4:0];
                3'd6: res = op.a | op.b;
                default: res = op.a & op.b;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex <= '0;
        end else begin
            ex <= '{valid: op.valid && !kill, cls: op.cls, funct3: op.funct3,
                    result: res, store_data: op.b, pc: op.pc, tag: op.tag};
        end
    end

endmodule

`default_nettype wire

//--- design/exec_ctrl.sv
// exec_ctrl: issue handshake, routing by op class, divider busy flag and flush
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  exec_pkg::issue_op_t issue,
    output logic                issue_ready,
    output exec_pkg::issue_op_t alu_in,
    output exec_pkg::issue_op_t mul_in,
    output exec_pkg::issue_op_t div_in,
    input  logic                div_done,
    output logic                kill
);
    import exec_pkg::*;

    logic run_q;
    logic div_busy;
    logic accept;
    logic is_mul;
    logic is_div;

    // divider frees the issue port in its done cycle
    assign issue_ready = run_q && (!div_busy || div_done);
    assign accept      = issue.valid && issue_ready && !flush;
    assign is_mul      = (issue.cls == CLS_MUL);
    assign is_div      = (issue.cls == CLS_DIV);
    assign kill        = flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_q    <= 1'b0;
            div_busy <= 1'b0;
            alu_in   <= '0;
            mul_in   <= '0;
            div_in   <= '0;
        end else begin
            run_q <= 1'b1;
            if (flush) begin
                div_busy <= 1'b0;
            end else if (accept && is_div) begin
                div_busy <= 1'b1;
            end else if (div_done) begin
                div_busy <= 1'b0;
            end
            alu_in       <= issue;
            alu_in.valid <= accept && !is_mul && !is_div;
            mul_in       <= issue;
            mul_in.valid <= accept && is_mul;
            div_in       <= issue;
            div_in.valid <= accept && is_div;
        end
    end

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
// exec_pkg: datapath types, op classes, stage records and divider states
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]  xlen_t;
    typedef logic [31:0]            pc_t;
    typedef logic [`EXEC_TAG_W-1:0] ptag_t;
    typedef logic [2:0]             funct3_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_MUL,
        CLS_DIV
    } op_class_e;

    // micro-op as it leaves the reservation stations
    typedef struct packed {
        logic      valid;
        op_class_e cls;
        funct3_t   funct3;
        logic      alt;
        xlen_t     a;
        xlen_t     b;
        xlen_t     imm;
        pc_t       pc;
        ptag_t     tag;
    } issue_op_t;

    // result is the alu value, or the address for loads and stores
    typedef struct packed {
        logic      valid;
        op_class_e cls;
        funct3_t   funct3;
        xlen_t     result;
        xlen_t     store_data;
        pc_t       pc;
        ptag_t     tag;
    } ex_op_t;

    typedef struct packed {
        logic  valid;
        xlen_t value;
        pc_t   pc;
        ptag_t tag;
    } cpl_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

`default_nettype wire

//--- design/exec_params.svh
// widths, data memory depth and pipeline depths of the execution back end
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath and physical tag widths
`define EXEC_XLEN 32
`define EXEC_TAG_W 8

// 32-bit words in the data memory
`define EXEC_MEM_WORDS 256

`define EXEC_MUL_STAGES 3
`define EXEC_DIV_CYCLES 32

`endif
